/* gb_bus_config.svh */
/*
 * Memory map, register offsets and widths of the console system bus.
 * Included by the packages and by every module that decodes addresses.
 */

`ifndef GB_BUS_CONFIG_SVH
`define GB_BUS_CONFIG_SVH

// Bus widths
`define GB_ADDR_W        16
`define GB_DATA_W        8
`define GB_WRAM_ADDR_W   13

// Work RAM and its echo
`define GB_WRAM_START    16'hC000
`define GB_WRAM_END      16'hDFFF
`define GB_ECHO_START    16'hE000
`define GB_ECHO_END      16'hFDFF

// Boot region runs from 0000 up to this address
`define GB_BOOT_END      16'h0102

// Register page and offsets inside it
`define GB_IO_PAGE       8'hFF
`define GB_REG_BOOTSTRAP 8'h50
`define GB_REG_IF        8'h0F
`define GB_REG_IE        8'hFF

// Number of interrupt sources
`define GB_IRQ_COUNT     5

`endif

/* gb_bus_pkg.sv */
/*
 * Types of the system bus: address word, request, response and the
 * decoded region. Imported by the fabric modules and the testbench.
 */
`default_nettype none

`include "gb_bus_config.svh"

package gb_bus_pkg;

   typedef logic [`GB_DATA_W-1:0]      bus_data_t;
   typedef logic [`GB_WRAM_ADDR_W-1:0] wram_index_t;

   // High byte selects the page, low byte the register in it
   typedef struct packed {
      logic [7:0] page;
      logic [7:0] offset;
   } addr_split_t;

   typedef union packed {
      logic [`GB_ADDR_W-1:0] word;
      addr_split_t           split;
   } bus_addr_t;

   // One byte access per strobe
   typedef struct packed {
      logic      strobe;
      logic      write;
      bus_addr_t addr;
      bus_data_t wdata;
   } bus_req_t;

   typedef struct packed {
      logic      valid;
      bus_data_t data;
   } bus_rsp_t;

   typedef enum logic [2:0] {
      reg_none,
      reg_boot,
      reg_wram,
      reg_bootstrap,
      reg_if,
      reg_ie
   } region_t;

endpackage

`default_nettype wire

/* gb_irq_pkg.sv */
/*
 * Interrupt source numbering and the vector type shared by IF, IE
 * and the outside interrupt sources.
 */
`default_nettype none

`include "gb_bus_config.svh"

package gb_irq_pkg;

   typedef logic [`GB_IRQ_COUNT-1:0] irq_vec_t;

   // Bit positions in IF and IE
   typedef enum logic [2:0] {
      irq_vblank = 3'd0,
      irq_lcdc   = 3'd1,
      irq_timer  = 3'd2,
      irq_serial = 3'd3,
      irq_joypad = 3'd4
   } irq_index_t;

endpackage

`default_nettype wire

/* memory_map.sv */
/*
 * Address decoder of the system bus. Folds work and echo RAM onto one
 * RAM index, holds the bootstrap register, forwards boot reads to flash
 * and returns one registered response per strobe.
 */
`default_nettype none

`include "gb_bus_config.svh"

module memory_map import gb_bus_pkg::*, gb_irq_pkg::*; (
   input  wire                   clock,
   input  wire                   reset,
   input  bus_req_t              req,
   input  bus_data_t             flash_data,
   input  bus_data_t             wram_rdata,
   input  irq_vec_t              if_q,
   input  irq_vec_t              ie_q,
   output bus_rsp_t              rsp,
   output logic [`GB_ADDR_W-1:0] flash_addr,
   output logic                  wram_we,
   output logic                  wram_re,
   output wram_index_t           wram_addr,
   output bus_data_t             wram_wdata,
   output logic                  if_we,
   output logic                  ie_we,
   output bus_data_t             reg_wdata
);

   localparam int PAD_W = `GB_DATA_W - `GB_IRQ_COUNT;

   bus_data_t             bootstrap_q;
   logic                  hit_boot, hit_wram, hit_echo, hit_io;
   logic                  hit_bootstrap, hit_if, hit_ie, hit_none;
   region_t               region;
   region_t               region_q;
   bus_data_t             src_byte;
   bus_data_t             byte_q;
   logic                  valid_q;
   logic                  rd, wr;

   assign rd = req.strobe & ~req.write;
   assign wr = req.strobe & req.write;

   // Whole-word range checks
   assign hit_boot = (req.addr.word <= `GB_BOOT_END) & ~bootstrap_q[0];
   assign hit_wram = (req.addr.word >= `GB_WRAM_START) & (req.addr.word <= `GB_WRAM_END);
   assign hit_echo = (req.addr.word >= `GB_ECHO_START) & (req.addr.word <= `GB_ECHO_END);

   // Register page, then offset
   assign hit_io        = (req.addr.split.page == `GB_IO_PAGE);
   assign hit_bootstrap = hit_io & (req.addr.split.offset == `GB_REG_BOOTSTRAP);
   assign hit_if        = hit_io & (req.addr.split.offset == `GB_REG_IF);
   assign hit_ie        = hit_io & (req.addr.split.offset == `GB_REG_IE);
   assign hit_none = ~(hit_boot | hit_wram | hit_echo | hit_bootstrap | hit_if | hit_ie);

   always_comb begin
      region = reg_none;
      if (hit_boot) begin
         region = reg_boot;
      end else if (hit_wram | hit_echo) begin
         region = reg_wram;
      end else if (hit_bootstrap) begin
         region = reg_bootstrap;
      end else if (hit_if) begin
         region = reg_if;
      end else if (hit_ie) begin
         region = reg_ie;
      end
   end

   // Work and echo both start on an 8 KiB boundary, so the low bits are the index
   assign wram_addr  = req.addr.word[`GB_WRAM_ADDR_W-1:0];
   assign wram_wdata = req.wdata;
   assign wram_we    = wr & (region == reg_wram);
   assign wram_re    = rd & (region == reg_wram);

   assign if_we     = wr & (region == reg_if);
   assign ie_we     = wr & (region == reg_ie);
   assign reg_wdata = req.wdata;

   assign flash_addr = req.addr.word;

   // Bit 0 hides the boot region once set
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         bootstrap_q <= '0;
      end else if (wr & (region == reg_bootstrap)) begin
         bootstrap_q <= req.wdata;
      end
   end

   // Byte of the non-RAM sources
   always_comb begin
      case (region)
         reg_boot:      src_byte = flash_data;
         reg_bootstrap: src_byte = bootstrap_q;
         reg_if:        src_byte = {{PAD_W{1'b0}}, if_q};
         reg_ie:        src_byte = {{PAD_W{1'b0}}, ie_q};
         default:       src_byte = '0;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         valid_q  <= 1'b0;
         region_q <= reg_none;
         byte_q   <= '0;
      end else begin
         valid_q  <= req.strobe;
         // Writes answer with zero
         region_q <= rd ? region : reg_none;
         byte_q   <= rd ? src_byte : '0;
      end
   end

   assign rsp = '{valid: valid_q,
                  data:  (region_q == reg_wram) ? wram_rdata : byte_q};

   // Decode terms never overlap on a live strobe
   a_region_onehot: assert property (@(posedge clock) disable iff (reset)
      req.strobe |-> $onehot({hit_boot, hit_wram, hit_echo, hit_bootstrap,
                              hit_if, hit_ie, hit_none}));

   // A response only follows a strobe
   a_rsp_after_strobe: assert property (@(posedge clock) disable iff (reset)
      $rose(rsp.valid) |-> $past(req.strobe));

endmodule

`default_nettype wire

/* interrupt_flags.sv */
/*
 * Interrupt flag (IF) and interrupt enable (IE) registers. Sources set
 * IF bits, the bus can overwrite either register, and irq_pending
 * reports a flagged interrupt that is also enabled.
 */
`default_nettype none

`include "gb_bus_config.svh"

module interrupt_flags import gb_bus_pkg::*, gb_irq_pkg::*; (
   input  wire       clock,
   input  wire       reset,
   input  irq_vec_t  irq_source,
   input  wire       if_we,
   input  wire       ie_we,
   input  bus_data_t reg_wdata,
   output irq_vec_t  if_q,
   output irq_vec_t  ie_q,
   output logic      irq_pending
);

   irq_vec_t wr_vec;

   // Only the low bits are backed by flops
   assign wr_vec = reg_wdata[`GB_IRQ_COUNT-1:0];

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_q <= '0;
      end else if (if_we) begin
         // Bus write replaces any pulse in the same cycle
         if_q <= wr_vec;
      end else begin
         if_q <= if_q | irq_source;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ie_q <= '0;
      end else if (ie_we) begin
         ie_q <= wr_vec;
      end
   end

   // Follows the registers by one cycle
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         irq_pending <= 1'b0;
      end else begin
         irq_pending <= |(if_q & ie_q);
      end
   end

   // The decoder selects at most one register per strobe
   a_single_reg_write: assert property (@(posedge clock) disable iff (reset)
      !(if_we && ie_we));

endmodule

`default_nettype wire

/* work_ram.sv */
/*
 * 8 KiB work RAM behind the decoder. Single port, write at the clock
 * edge, read data registered and valid one cycle after wram_re.
 */
`default_nettype none

`include "gb_bus_config.svh"

module work_ram import gb_bus_pkg::*; (
   input  wire         clock,
   input  wire         wram_we,
   input  wire         wram_re,
   input  wram_index_t wram_addr,
   input  bus_data_t   wram_wdata,
   output bus_data_t   wram_rdata
);

   localparam int DEPTH = 1 << `GB_WRAM_ADDR_W;

   bus_data_t mem [0:DEPTH-1];

   always_ff @(posedge clock) begin
      if (wram_we) begin
         mem[wram_addr] <= wram_wdata;
      end
   end

   // Output holds between reads
   always_ff @(posedge clock) begin
      if (wram_re) begin
         wram_rdata <= mem[wram_addr];
      end
   end

endmodule

`default_nettype wire

/* gb_bus_top.sv */
/*
 * System bus fabric top level. Joins the decoder, the interrupt
 * registers and the work RAM; the master and flash sit outside.
 */
`default_nettype none

`include "gb_bus_config.svh"

module gb_bus_top import gb_bus_pkg::*, gb_irq_pkg::*; (
   input  wire                   clock,
   input  wire                   reset,
   input  bus_req_t              req,
   input  irq_vec_t              irq_source,
   input  bus_data_t             flash_data,
   output bus_rsp_t              rsp,
   output logic [`GB_ADDR_W-1:0] flash_addr,
   output logic                  irq_pending
);

   logic        wram_we, wram_re;
   wram_index_t wram_addr;
   bus_data_t   wram_wdata, wram_rdata;
   logic        if_we, ie_we;
   bus_data_t   reg_wdata;
   irq_vec_t    if_q, ie_q;

   memory_map u_memory_map (
      .clock      (clock),
      .reset      (reset),
      .req        (req),
      .flash_data (flash_data),
      .wram_rdata (wram_rdata),
      .if_q       (if_q),
      .ie_q       (ie_q),
      .rsp        (rsp),
      .flash_addr (flash_addr),
      .wram_we    (wram_we),
      .wram_re    (wram_re),
      .wram_addr  (wram_addr),
      .wram_wdata (wram_wdata),
      .if_we      (if_we),
      .ie_we      (ie_we),
      .reg_wdata  (reg_wdata)
   );

   interrupt_flags u_interrupt_flags (
      .clock       (clock),
      .reset       (reset),
      .irq_source  (irq_source),
      .if_we       (if_we),
      .ie_we       (ie_we),
      .reg_wdata   (reg_wdata),
      .if_q        (if_q),
      .ie_q        (ie_q),
      .irq_pending (irq_pending)
   );

   work_ram u_work_ram (
      .clock      (clock),
      .wram_we    (wram_we),
      .wram_re    (wram_re),
      .wram_addr  (wram_addr),
      .wram_wdata (wram_wdata),
      .wram_rdata (wram_rdata)
   );

endmodule

`default_nettype wire

/* tb_gb_bus.sv */
/*
 * Directed testbench for the system bus fabric. Drives byte accesses and
 * interrupt pulses into gb_bus_top, models the boot flash and checks
 * every response against the memory map rules.
 */
`default_nettype none

`include "gb_bus_config.svh"

module tb_gb_bus import gb_bus_pkg::*, gb_irq_pkg::*;;

   localparam int CLOCK_PERIOD   = 40;
   localparam int TIMEOUT_CYCLES = 2000;

   logic                  clock;
   logic                  reset;
   bus_req_t              req;
   irq_vec_t              irq_source;
   bus_data_t             flash_data;
   bus_rsp_t              rsp;
   logic [`GB_ADDR_W-1:0] flash_addr;
   logic                  irq_pending;

   integer seed;
   int     cycle_count;
   int     check_count;
   int     mismatch_count;
   int     failure_count;

   gb_bus_top UUT (
      .clock       (clock),
      .reset       (reset),
      .req         (req),
      .irq_source  (irq_source),
      .flash_data  (flash_data),
      .rsp         (rsp),
      .flash_addr  (flash_addr),
      .irq_pending (irq_pending)
   );

   // Boot flash contents follow the address
   assign flash_data = flash_addr[7:0] ^ 8'hA5;

   initial begin
      clock = 1'b0;
      forever begin
         #(CLOCK_PERIOD / 2) clock = ~clock;
      end
   end

   // Ends the run if the tests stall
   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clock);
         cycle_count++;
      end
      $display("Timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   function automatic bus_data_t random_byte();
      integer r;
      r = $random(seed);
      return r[7:0];
   endfunction

   function automatic bus_data_t flash_byte(input logic [15:0] addr);
      return addr[7:0] ^ 8'hA5;
   endfunction

   function automatic irq_vec_t irq_bit(input irq_index_t index);
      irq_vec_t vec;
      vec = '0;
      vec[index] = 1'b1;
      return vec;
   endfunction

   task automatic check_response(input logic [15:0] addr, input bus_data_t expected);
      check_count++;
      if (rsp.valid !== 1'b1) begin
         failure_count++;
         $display("No response at %0t: rsp.valid was low one cycle after the access to %h",
                  $time, addr);
      end else if (rsp.data !== expected) begin
         mismatch_count++;
         $display("Mismatch at %0t: address %h, expected %h, seen %h",
                  $time, addr, expected, rsp.data);
      end
   endtask

   // Flash sees the full request address
   task automatic check_flash_addr(input logic [15:0] addr);
      check_count++;
      if (flash_addr !== addr) begin
         mismatch_count++;
         $display("Mismatch at %0t: flash_addr expected %h, seen %h",
                  $time, addr, flash_addr);
      end
   endtask

   // Called on a falling edge, returns on the next one
   task automatic issue_access(input logic write, input logic [15:0] addr,
                               input bus_data_t wdata, input bus_data_t expected);
      req.strobe    = 1'b1;
      req.write     = write;
      req.addr.word = addr;
      req.wdata     = wdata;
      @(negedge clock);
      check_response(addr, expected);
      check_flash_addr(addr);
      req = '0;
   endtask

   task automatic bus_write(input logic [15:0] addr, input bus_data_t data);
      // Writes answer with zero data
      issue_access(1'b1, addr, data, 8'h00);
   endtask

   task automatic bus_read(input logic [15:0] addr, input bus_data_t expected);
      issue_access(1'b0, addr, 8'h00, expected);
   endtask

   task automatic check_idle();
      @(negedge clock);
      check_count++;
      if (rsp.valid !== 1'b0) begin
         failure_count++;
         $display("Extra response at %0t: rsp.valid high with no strobe the cycle before",
                  $time);
      end
   endtask

   task automatic check_pending(input logic expected);
      check_count++;
      if (irq_pending !== expected) begin
         mismatch_count++;
         $display("Mismatch at %0t: irq_pending expected %b, seen %b",
                  $time, expected, irq_pending);
      end
   endtask

   task automatic pulse_irq(input irq_vec_t sources);
      irq_source = sources;
      @(negedge clock);
      irq_source = '0;
   endtask

   task automatic test_work_ram();
      bus_data_t d [0:4];
      for (int i = 0; i < 5; i++) begin
         d[i] = random_byte();
      end
      bus_write(16'hC000, d[0]);
      bus_write(16'hD123, d[1]);
      bus_write(16'hDFFF, d[2]);
      bus_read(16'hC000, d[0]);
      bus_read(16'hD123, d[1]);
      bus_read(16'hDFFF, d[2]);
      // Echo and work addresses share bytes
      bus_write(16'hE010, d[3]);
      bus_read(16'hC010, d[3]);
      bus_write(16'hC200, d[4]);
      bus_read(16'hE200, d[4]);
   endtask

   task automatic test_boot_region();
      bus_read(16'h0000, flash_byte(16'h0000));
      bus_read(16'h0080, flash_byte(16'h0080));
      bus_read(16'h0102, flash_byte(16'h0102));
      bus_read(16'h0103, 8'h00);
      // Setting bit 0 hides the boot flash
      bus_write(16'hFF50, 8'h01);
      bus_read(16'hFF50, 8'h01);
      bus_read(16'h0000, 8'h00);
   endtask

   task automatic test_unmapped_and_timing();
      bus_data_t d0;
      bus_data_t d1;
      bus_data_t d2;
      d0 = random_byte();
      d1 = random_byte();
      d2 = random_byte();
      bus_read(16'h8000, 8'h00);
      bus_read(16'hFF40, 8'h00);
      bus_read(16'hFF10, 8'h00);
      check_idle();
      // Four strobes in a row, one response per cycle
      bus_write(16'hC300, d0);
      bus_read(16'hC300, d0);
      bus_write(16'hE301, d1);
      bus_read(16'hC301, d1);
      check_idle();
      // FE00 would fold onto DE00 if the echo range leaked
      bus_write(16'hDE00, d2);
      bus_write(16'hFE00, ~d2);
      bus_write(16'hFF40, 8'h3C);
      bus_write(16'h0010, 8'h5A);
      bus_read(16'hDE00, d2);
      bus_read(16'hFF40, 8'h00);
      bus_read(16'hFF50, 8'h01);
      bus_read(16'hFF0F, 8'h00);
      bus_read(16'hFFFF, 8'h00);
   endtask

   task automatic test_irq_flags();
      pulse_irq(irq_bit(irq_vblank));
      pulse_irq(irq_bit(irq_timer));
      bus_read(16'hFF0F, 8'h05);
      bus_write(16'hFF0F, 8'h00);
      bus_read(16'hFF0F, 8'h00);
      // Bus write wins over a pulse in the same cycle
      irq_source = irq_bit(irq_joypad);
      bus_write(16'hFF0F, 8'h02);
      irq_source = '0;
      bus_read(16'hFF0F, 8'h02);
   endtask

   task automatic test_irq_enable();
      bus_write(16'hFF0F, 8'h00);
      bus_write(16'hFFFF, 8'h1F);
      bus_read(16'hFFFF, 8'h1F);
      check_idle();
      check_pending(1'b0);
      pulse_irq(irq_bit(irq_serial));
      // Pending lags IF by one cycle
      check_pending(1'b0);
      @(negedge clock);
      check_pending(1'b1);
      bus_write(16'hFF0F, 8'h00);
      @(negedge clock);
      check_pending(1'b0);
      bus_write(16'hFFFF, 8'h00);
      pulse_irq(irq_bit(irq_vblank));
      repeat (2) @(negedge clock);
      check_pending(1'b0);
   endtask

   initial begin
      seed           = 32'h100f_b5fe;
      check_count    = 0;
      mismatch_count = 0;
      failure_count  = 0;
      reset          = 1'b1;
      req            = '0;
      irq_source     = '0;
      repeat (4) @(negedge clock);
      reset = 1'b0;
      check_pending(1'b0);
      check_idle();

      test_work_ram();
      test_boot_region();
      test_unmapped_and_timing();
      test_irq_flags();
      test_irq_enable();

      @(negedge clock);
      $display("Checks: %0d, mismatches: %0d, other errors: %0d",
               check_count, mismatch_count, failure_count);
      if (mismatch_count + failure_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
gb_bus_pkg.sv
gb_irq_pkg.sv
memory_map.sv
interrupt_flags.sv
work_ram.sv
gb_bus_top.sv
tb_gb_bus.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_gb_bus \
   || { echo "Build failed"; exit 1; }

output="$(./obj_dir/Vtb_gb_bus)"
echo "$output"

echo "$output" | grep -qx "TEST OK" && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
